// ==== common/focus_pkg.sv ====
package focus_pkg;

    // array geometry
    localparam int num_elements = 16;
    localparam int array_cols   = 4;

    // datapath widths
    localparam int coord_w = 8;   // signed focal coordinate
    localparam int pos_w   = 9;   // focal point relative to one element
    localparam int rsq_w   = 19;  // squared radius
    localparam int delay_w = 8;

    localparam logic [delay_w-1:0] delay_base = 8'd147;
    localparam logic [delay_w-1:0] delay_max  = 8'd179;

    // focus register plus lane register
    localparam int settle_cycles = 2;

    // element centres at +-40 and +-120, pitch of 80
    // same table serves columns (x) and rows (y)
    localparam logic signed [pos_w-1:0] element_offsets [0:array_cols-1] = '{
        9'sd120,
        9'sd40,
        -9'sd40,
        -9'sd120
    };

    // ascending upper bounds on r^2
    // delay = delay_base + number of bounds exceeded
    localparam int num_bounds = 32;

    localparam logic [rsq_w-1:0] delay_bounds [0:num_bounds-1] = '{
        19'd3844,   19'd12544,  19'd21316,  19'd29929,   // r 62 .. 173
        19'd38809,  19'd47961,  19'd57121,  19'd66049,
        19'd75076,  19'd84100,  19'd93636,  19'd103041,
        19'd112225, 19'd121801, 19'd131044, 19'd140625,
        19'd150544, 19'd160000, 19'd169744, 19'd179776,
        19'd190096, 19'd199809, 19'd209764, 19'd219961,
        19'd229441, 19'd240100, 19'd250000, 19'd260100,
        19'd270400, 19'd280900, 19'd291600, 19'd302500   // r 520 .. 550
    };

    // focal point relative to the array centre
    typedef struct packed {
        logic signed [coord_w-1:0] x;
        logic signed [coord_w-1:0] y;
    } focus_point_t;

    // one firing delay per element, slot i belongs to element i
    typedef logic [num_elements-1:0][delay_w-1:0] element_delays_t;

endpackage

// ==== source/focus_latch.sv ====
`timescale 1ns/1ps

module focus_latch import focus_pkg::*; (
    input  logic         i_clk,
    input  logic         arst_n,
    input  logic         focus_load,
    input  focus_point_t focus_in,
    output focus_point_t focus,
    output logic         delays_ready
);

    localparam int settle_w = $clog2(settle_cycles + 1);

    logic [settle_w-1:0] settle_cnt;

    always_ff @(posedge i_clk or negedge arst_n) begin
        if (!arst_n) begin
            focus <= '0;
        end else if (focus_load) begin
            focus <= focus_in;
        end
    end

    // every load restarts the settle count
    // back to back loads keep delays_ready low until the newest point reaches the lanes
    always_ff @(posedge i_clk or negedge arst_n) begin
        if (!arst_n) begin
            settle_cnt   <= '0;
            delays_ready <= 1'b0;
        end else if (focus_load) begin
            settle_cnt   <= settle_w'(settle_cycles);
            delays_ready <= 1'b0;
        end else if (settle_cnt != '0) begin
            settle_cnt <= settle_cnt - 1'b1;
            if (settle_cnt == settle_w'(1)) begin
                delays_ready <= 1'b1;   // lanes registered the new point
            end
        end
    end

    // ready only once the point has passed focus and lane registers
    assert property (@(posedge i_clk) disable iff (!arst_n)
        delays_ready |-> !$past(focus_load) && !$past(focus_load, 2))
        else $error("delays_ready high within two cycles of a focus load");

endmodule

// ==== element_delay/element_delay.sv ====
`timescale 1ns/1ps

module element_delay import focus_pkg::*; #(
    parameter int element_index = 0
) (
    input  logic               i_clk,
    input  logic               arst_n,
    input  focus_point_t       focus,
    output logic [delay_w-1:0] delay
);

    // position of this element in the grid
    localparam int col = element_index % array_cols;
    localparam int row = element_index / array_cols;

    localparam logic signed [pos_w-1:0] off_x = element_offsets[col];
    localparam logic signed [pos_w-1:0] off_y = element_offsets[row];

    logic signed [pos_w-1:0]   rel_x;
    logic signed [pos_w-1:0]   rel_y;
    logic signed [2*pos_w-1:0] sq_x;
    logic signed [2*pos_w-1:0] sq_y;
    logic [rsq_w-1:0]          rsq;
    logic [delay_w-1:0]        steps;
    logic [delay_w-1:0]        delay_next;

    // focal point seen from this element, sign extended first
    // range -248 .. 247 fits pos_w
    assign rel_x = $signed({focus.x[coord_w-1], focus.x}) + off_x;
    assign rel_y = $signed({focus.y[coord_w-1], focus.y}) + off_y;

    assign sq_x = rel_x * rel_x;
    assign sq_y = rel_y * rel_y;

    // both squares are non-negative, top bit is free
    assign rsq = {1'b0, sq_x} + {1'b0, sq_y};

    // threshold count instead of a range case, table is ascending
    always_comb begin
        steps = '0;
        for (int i = 0; i < num_bounds; i++) begin
            if (rsq > delay_bounds[i]) begin
                steps = steps + 1'b1;
            end
        end
    end

    assign delay_next = delay_base + steps;

    always_ff @(posedge i_clk or negedge arst_n) begin
        if (!arst_n) begin
            delay <= delay_base;
        end else begin
            delay <= delay_next;
        end
    end

    // scheduler counter window assumes this range
    assert property (@(posedge i_clk) disable iff (!arst_n)
        (delay >= delay_base) && (delay <= delay_max))
        else $error("element %0d delay %0d out of range", element_index, delay);

endmodule

// ==== source/fire_scheduler.sv ====
`timescale 1ns/1ps

module fire_scheduler import focus_pkg::*; (
    input  logic                    i_clk,
    input  logic                    arst_n,
    input  logic                    fire,
    input  logic                    delays_ready,
    input  element_delays_t         delays,
    output logic [num_elements-1:0] tx_pulse,
    output logic                    busy
);

    element_delays_t    snap;   // delays frozen for the current shot
    logic [delay_w-1:0] tick;
    logic               accept;

    // fires that arrive early or mid shot are dropped
    assign accept = fire && delays_ready && !busy;

    // snapshot keeps a focus reload from moving pulses of a running shot
    always_ff @(posedge i_clk or negedge arst_n) begin
        if (!arst_n) begin
            snap <= {num_elements{delay_base}};
        end else if (accept) begin
            snap <= delays;
        end
    end

    always_ff @(posedge i_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            tick <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            tick <= delay_w'(1);   // first cycle after the accepting edge
        end else if (busy) begin
            if (tick == delay_max) begin
                busy <= 1'b0;
                tick <= '0;
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    // tick rests at 0 while idle and no delay is 0
    // each value passes once per shot
    always_comb begin
        for (int i = 0; i < num_elements; i++) begin
            tx_pulse[i] = (tick == snap[i]);
        end
    end

    assert property (@(posedge i_clk) disable iff (!arst_n)
        !busy |-> (tx_pulse == '0))
        else $error("transmit pulse while idle");

    // shot start needs an accepted fire on the previous edge
    assert property (@(posedge i_clk) disable iff (!arst_n)
        $rose(busy) |-> $past(fire && delays_ready))
        else $error("busy rose without a valid fire");

endmodule

// ==== source/phased_array_focus_top.sv ====
`timescale 1ns/1ps

module phased_array_focus_top import focus_pkg::*; (
    input  logic                    i_clk,
    input  logic                    arst_n,
    input  logic                    focus_load,
    input  focus_point_t            focus_in,
    input  logic                    fire,
    output logic [num_elements-1:0] tx_pulse,
    output logic                    busy,
    output logic                    delays_ready
);

    focus_point_t    focus;
    element_delays_t delays;

    focus_latch u_focus_latch (
        .i_clk        (i_clk),
        .arst_n       (arst_n),
        .focus_load   (focus_load),
        .focus_in     (focus_in),
        .focus        (focus),
        .delays_ready (delays_ready)
    );

    // one lane per element, index picks its grid offsets
    genvar idx;
    generate
        for (idx = 0; idx < num_elements; idx++) begin : g_lane
            element_delay #(
                .element_index (idx)
            ) u_element_delay (
                .i_clk  (i_clk),
                .arst_n (arst_n),
                .focus  (focus),
                .delay  (delays[idx])
            );
        end
    endgenerate

    fire_scheduler u_fire_scheduler (
        .i_clk        (i_clk),
        .arst_n       (arst_n),
        .fire         (fire),
        .delays_ready (delays_ready),
        .delays       (delays),
        .tx_pulse     (tx_pulse),
        .busy         (busy)
    );

endmodule

// ==== testbench/tb_phased_array_focus.sv ====
`timescale 1ns/1ps

module tb_phased_array_focus import focus_pkg::*; ();

    localparam int num_rounds    = 40;
    localparam int round_cycles  = 200;
    localparam int cycle_limit   = num_rounds * round_cycles + 2000;
    localparam int load_latency  = 2;   // load edge to delays_ready
    localparam int num_random    = 30;

    logic                    i_clk;
    logic                    arst_n;
    logic                    focus_load;
    focus_point_t            focus_in;
    logic                    fire;
    logic [num_elements-1:0] tx_pulse;
    logic                    busy;
    logic                    delays_ready;

    logic         expect_accept;   // set with fire when the fire must start a shot
    logic         any_load;
    focus_point_t loaded_focus;

    logic shot_active;
    int   shot_cycle;
    int   exp_cycle   [num_elements];
    int   pulse_count [num_elements];
    int   pulse_at    [num_elements];

    int shots_started;
    int shots_checked;
    int value_errors;
    int missing_errors;
    int cycle_count;

    phased_array_focus_top dut0 (
        .i_clk        (i_clk),
        .arst_n       (arst_n),
        .focus_load   (focus_load),
        .focus_in     (focus_in),
        .fire         (fire),
        .tx_pulse     (tx_pulse),
        .busy         (busy),
        .delays_ready (delays_ready)
    );

    always #20 i_clk = ~i_clk;

    // delay = base + number of r^2 bounds exceeded
    function automatic int expected_delay(input focus_point_t p, input int idx);
        int col;
        int row;
        int rx;
        int ry;
        int rsq;
        int count;
        begin
            col   = idx % array_cols;
            row   = idx / array_cols;
            rx    = int'(p.x) + int'(element_offsets[col]);
            ry    = int'(p.y) + int'(element_offsets[row]);
            rsq   = rx * rx + ry * ry;
            count = 0;
            for (int j = 0; j < num_bounds; j++) begin
                if (rsq > int'(delay_bounds[j])) begin
                    count++;
                end
            end
            return int'(delay_base) + count;
        end
    endfunction

    // pulse checker sampling on the falling edge
    always @(negedge i_clk) begin
        if (!shot_active) begin
            if (tx_pulse != '0) begin
                $display("ERROR @%0t: tx_pulse %h while no shot is running", $time, tx_pulse);
                value_errors++;
            end
            if (busy) begin
                $display("ERROR @%0t: busy high while no shot is running", $time);
                value_errors++;
            end
            if (!any_load && delays_ready) begin
                $display("ERROR @%0t: delays_ready high before any focus load", $time);
                value_errors++;
            end
            if (arst_n && fire && expect_accept) begin
                shot_active = 1'b1;
                shot_cycle  = 0;   // next edge accepts the fire
                for (int i = 0; i < num_elements; i++) begin
                    exp_cycle[i]   = expected_delay(loaded_focus, i);
                    pulse_count[i] = 0;
                    pulse_at[i]    = -1;
                end
            end
        end else begin
            shot_cycle++;
            for (int i = 0; i < num_elements; i++) begin
                if (tx_pulse[i]) begin
                    pulse_count[i]++;
                    pulse_at[i] = shot_cycle;
                    if (shot_cycle != exp_cycle[i]) begin
                        $display("ERROR @%0t: element %0d pulsed at cycle %0d, expected %0d",
                                 $time, i, shot_cycle, exp_cycle[i]);
                        value_errors++;
                    end
                end
            end
            if (shot_cycle <= int'(delay_max)) begin
                if (!busy) begin
                    $display("ERROR @%0t: busy low at cycle %0d of a shot", $time, shot_cycle);
                    value_errors++;
                end
            end else begin
                if (busy) begin
                    $display("ERROR @%0t: busy still high after cycle %0d",
                             $time, int'(delay_max));
                    value_errors++;
                end
                for (int i = 0; i < num_elements; i++) begin
                    if (pulse_count[i] == 0) begin
                        $display("element %0d never pulsed during the shot, expected at cycle %0d",
                                 i, exp_cycle[i]);
                        missing_errors++;
                    end else if (pulse_count[i] > 1) begin
                        $display("ERROR @%0t: element %0d pulsed %0d times in one shot",
                                 $time, i, pulse_count[i]);
                        value_errors++;
                    end
                end
                shot_active = 1'b0;
                shots_checked++;
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles, stopped by timeout", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic wait_ready(output int cycles);
        begin
            cycles = 0;
            @(negedge i_clk);
            while (!delays_ready) begin
                cycles++;
                @(negedge i_clk);
            end
        end
    endtask

    task automatic load_start(input focus_point_t p);
        begin
            @(posedge i_clk);
            focus_load <= 1'b1;
            focus_in   <= p;
            @(posedge i_clk);   // load edge
            focus_load <= 1'b0;
            loaded_focus = p;
            any_load     = 1'b1;
        end
    endtask

    task automatic load_focus(input focus_point_t p);
        int cycles;
        begin
            load_start(p);
            wait_ready(cycles);
            if (cycles != load_latency) begin
                $display("ERROR @%0t: delays_ready after %0d cycles, expected %0d",
                         $time, cycles, load_latency);
                value_errors++;
            end
        end
    endtask

    task automatic start_shot;
        begin
            @(posedge i_clk);
            fire          <= 1'b1;
            expect_accept <= 1'b1;
            @(posedge i_clk);   // accepting edge
            fire          <= 1'b0;
            expect_accept <= 1'b0;
            shots_started++;
        end
    endtask

    // fire that the scheduler has to drop
    task automatic fire_ignored;
        begin
            @(posedge i_clk);
            fire          <= 1'b1;
            expect_accept <= 1'b0;
            @(posedge i_clk);
            fire <= 1'b0;
        end
    endtask

    task automatic wait_shot_done;
        begin
            while (shot_active) begin
                @(posedge i_clk);
            end
        end
    endtask

    task automatic check_mirrors;
        int col;
        int row;
        int flip_x;
        int flip_y;
        begin
            for (int i = 0; i < num_elements; i++) begin
                col    = i % array_cols;
                row    = i / array_cols;
                flip_x = row * array_cols + (array_cols - 1 - col);
                flip_y = (array_cols - 1 - row) * array_cols + col;
                if (pulse_at[i] != pulse_at[flip_x] || pulse_at[i] != pulse_at[flip_y]) begin
                    $display("ERROR @%0t: centre focus, element %0d not in step with its mirrors",
                             $time, i);
                    value_errors++;
                end
            end
        end
    endtask

    function automatic focus_point_t random_point(input int k);
        focus_point_t p;
        begin
            case (k)
                0: begin
                    p.x = -8'sd128;
                    p.y = -8'sd128;
                end
                1: begin
                    p.x = 8'sd127;
                    p.y = 8'sd127;
                end
                2: begin
                    p.x = -8'sd128;
                    p.y = 8'sd127;
                end
                3: begin
                    p.x = 8'sd127;
                    p.y = -8'sd128;
                end
                default: begin
                    p.x = coord_w'($urandom);
                    p.y = coord_w'($urandom);
                end
            endcase
            return p;
        end
    endfunction

    initial begin
        int unsigned  seed_value;
        int           ready_wait;
        focus_point_t p;

        i_clk         = 1'b0;
        arst_n        = 1'b0;
        focus_load    = 1'b0;
        focus_in      = '0;
        fire          = 1'b0;
        expect_accept = 1'b0;
        any_load      = 1'b0;
        loaded_focus  = '0;
        shot_active   = 1'b0;
        shot_cycle    = 0;
        shots_started = 0;
        shots_checked = 0;
        value_errors  = 0;
        missing_errors = 0;
        cycle_count   = 0;
        ready_wait    = 0;
        seed_value    = $urandom(66404);

        repeat (5) @(posedge i_clk);
        arst_n <= 1'b1;
        repeat (3) @(posedge i_clk);

        // nothing loaded yet
        fire_ignored;
        repeat (5) @(posedge i_clk);

        p.x = 8'sd0;
        p.y = 8'sd0;
        load_focus(p);
        start_shot;
        wait_shot_done;
        check_mirrors;

        for (int k = 0; k < num_random; k++) begin
            load_focus(random_point(k));
            start_shot;
            wait_shot_done;
        end

        // fire right after a load before the lanes settle
        p.x = 8'sd37;
        p.y = -8'sd90;
        load_start(p);
        fire_ignored;
        wait_ready(ready_wait);
        if (ready_wait != load_latency - 2) begin   // dropped fire spans two settle edges
            $display("ERROR @%0t: delays_ready %0d cycles late after a dropped fire",
                     $time, ready_wait);
            value_errors++;
        end
        repeat (5) @(posedge i_clk);

        // fires in the middle of a running shot
        start_shot;
        repeat (40) @(posedge i_clk);
        fire_ignored;
        repeat (60) @(posedge i_clk);
        fire_ignored;
        wait_shot_done;

        // reload while firing
        // running shot keeps the old point
        start_shot;
        repeat (60) @(posedge i_clk);
        p.x = -8'sd100;
        p.y = 8'sd55;
        load_focus(p);
        wait_shot_done;
        start_shot;
        wait_shot_done;

        repeat (10) @(posedge i_clk);

        if (shots_checked != shots_started) begin
            $display("only %0d of %0d shots were checked to the end",
                     shots_checked, shots_started);
        end
        $display("summary: %0d shots checked, %0d value errors, %0d missing pulses",
                 shots_checked, value_errors, missing_errors);
        if (value_errors == 0 && missing_errors == 0 && shots_checked == shots_started) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== phased_array_focus_top.f ====
common/focus_pkg.sv
source/focus_latch.sv
element_delay/element_delay.sv
source/fire_scheduler.sv
source/phased_array_focus_top.sv
testbench/tb_phased_array_focus.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 \
    --top-module tb_phased_array_focus \
    -f phased_array_focus_top.f \
    -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Verification passed" &&
echo "simulation run passed" ||
{ echo "simulation run failed"; exit 1; }
